// File: bench/acq_checker.sv
`timescale 1ns/1ps

module acq_checker (
    input logic                        AXIS_ACLK,
    input logic                        AXIS_ARESETN,
    input logic                        s_tready,
    input logic [acq_pkg::M_WIDTH-1:0] m_tdata,
    input logic                        m_tvalid,
    input logic                        m_tready,
    input logic                        m_tuser,
    input logic                        m_tlast
);

    // output beat frozen while the sink stalls
    property hold_while_stalled;
        @(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        (m_tvalid && !m_tready) |=>
            (m_tvalid && $stable(m_tdata) && $stable(m_tuser) && $stable(m_tlast));
    endproperty

    // no output beat offered under reset
    property quiet_in_reset;
        @(posedge AXIS_ACLK) !AXIS_ARESETN |=> !m_tvalid;
    endproperty

    // ADC side is never stalled
    property input_always_ready;
        @(posedge AXIS_ACLK) AXIS_ARESETN |-> s_tready;
    endproperty

    assert property (hold_while_stalled)
        else $error("output beat changed while m_tvalid was high and m_tready low");

    assert property (quiet_in_reset)
        else $error("m_tvalid was high during reset");

    assert property (input_always_ready)
        else $error("s_tready was low outside reset");

endmodule

// File: bench/acq_clock_gen.sv
`timescale 1ns/1ps

module acq_clock_gen (
    output logic AXIS_ACLK,
    output logic AXIS_ARESETN
);
    localparam int HALF_PERIOD_NS = 4;
    localparam int RESET_CYCLES   = 10;

    // 8 ns clock
    initial
    begin
        AXIS_ACLK = 1'b0;
        forever
        begin
            #HALF_PERIOD_NS AXIS_ACLK = ~AXIS_ACLK;
        end
    end

    // release just after a rising edge
    initial
    begin
        AXIS_ARESETN = 1'b0;
        repeat (RESET_CYCLES) @(posedge AXIS_ACLK);
        #1 AXIS_ARESETN = 1'b1;
    end

endmodule

// File: bench/acq_tb.sv
`timescale 1ns/1ps

module acq_tb;
    import acq_pkg::*;

    localparam int N_CYCLES      = 4000;
    localparam int CLK_NS        = 8;
    localparam int MARGIN_CYCLES = 2000;

    typedef struct packed {
        logic [M_WIDTH-1:0] data;
        logic               user;
        logic               last;
    } out_word_t;

    logic               AXIS_ACLK;
    logic               AXIS_ARESETN;
    logic [S_WIDTH-1:0] s_tdata;
    logic               s_tvalid;
    logic               s_tready;
    logic [M_WIDTH-1:0] m_tdata;
    logic               m_tvalid;
    logic               m_tready;
    logic               m_tuser;
    logic               m_tlast;
    logic               busy;

    integer seed;
    int     high_left;
    int     stall_left;

    // reference model state
    buf_state_e             ref_state;
    int                     ref_fill;
    int                     ref_post_left;
    logic                   ref_prev_high;
    logic [STAMP_WIDTH-1:0] ref_beat_cnt;
    logic [S_WIDTH-1:0]     history [$];
    out_word_t              expected [$];
    int                     word_idx;
    int                     records_expected;
    int                     records_seen;
    logic                   exp_busy;
    logic                   hit_prev;

    acq_clock_gen u_clock_gen (
        .AXIS_ACLK    (AXIS_ACLK),
        .AXIS_ARESETN (AXIS_ARESETN)
    );

    acq_top UUT (
        .AXIS_ACLK    (AXIS_ACLK),
        .AXIS_ARESETN (AXIS_ARESETN),
        .s_tdata      (s_tdata),
        .s_tvalid     (s_tvalid),
        .s_tready     (s_tready),
        .m_tdata      (m_tdata),
        .m_tvalid     (m_tvalid),
        .m_tready     (m_tready),
        .m_tuser      (m_tuser),
        .m_tlast      (m_tlast),
        .busy         (busy)
    );

    bind acq_top acq_checker u_checker (
        .AXIS_ACLK    (AXIS_ACLK),
        .AXIS_ARESETN (AXIS_ARESETN),
        .s_tready     (s_tready),
        .m_tdata      (m_tdata),
        .m_tvalid     (m_tvalid),
        .m_tready     (m_tready),
        .m_tuser      (m_tuser),
        .m_tlast      (m_tlast)
    );

    task automatic check_value(input string name, input logic [M_WIDTH-1:0] exp_val,
                               input logic [M_WIDTH-1:0] act_val);
        if (act_val !== exp_val)
        begin
            $display("FAILED %s: expected %h, actual %h", name, exp_val, act_val);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run aborted");
    endtask

    // any lane code at or above the trigger level
    function automatic logic beat_is_high(input logic [S_WIDTH-1:0] beat);
        logic high;
        high = 1'b0;
        for (int i = 0; i < LANES; i++)
        begin
            if (beat[i*LANE_WIDTH +: ADC_BITS] >= THRESHOLD_LEVEL)
            begin
                high = 1'b1;
            end
        end
        return high;
    endfunction

    // low half goes out first
    task automatic push_beat(input logic [S_WIDTH-1:0] beat, input logic first,
                             input logic last);
        expected.push_back({beat[M_WIDTH-1:0], first, 1'b0});
        expected.push_back({beat[S_WIDTH-1 -: M_WIDTH], 1'b0, last});
    endtask

    task automatic model_accept(input logic [S_WIDTH-1:0] beat, output logic hit);
        logic high;
        high = beat_is_high(beat);
        hit  = 1'b0;
        case (ref_state)
            FILL:
            begin
                if (high && !ref_prev_high && (ref_fill >= PRE_LEN))
                begin
                    hit = 1'b1;
                    push_beat(S_WIDTH'(ref_beat_cnt), 1'b1, 1'b0);
                    foreach (history[i])
                    begin
                        push_beat(history[i], 1'b0, 1'b0);
                    end
                    push_beat(beat, 1'b0, 1'b0);
                    ref_state     = POST;
                    ref_post_left = POST_LEN;
                    records_expected++;
                end
                else
                begin
                    ref_fill++;
                end
            end
            POST:
            begin
                push_beat(beat, 1'b0, ref_post_left == 1);
                ref_post_left--;
                if (ref_post_left == 0)
                begin
                    ref_state = DRAIN;
                end
            end
            default:
            begin
                // dropped until the record has left
            end
        endcase
        ref_prev_high = high;
        ref_beat_cnt++;
        history.push_back(beat);
        if (history.size() > PRE_LEN)
        begin
            void'(history.pop_front());
        end
    endtask

    task automatic drive_input(input bit allow_high);
        logic [S_WIDTH-1:0] beat;
        int                 lane;
        bit                 make_high;
        s_tvalid  = ({$random(seed)} % 10) < 8;
        make_high = 1'b0;
        if (allow_high && (high_left > 0))
        begin
            make_high = 1'b1;
            high_left--;
        end
        else if (allow_high && ({$random(seed)} % 12 == 0))
        begin
            high_left = 1 + {$random(seed)} % 4;
        end
        for (int i = 0; i < LANES; i++)
        begin
            // junk in the unused top bits
            beat[i*LANE_WIDTH +: LANE_WIDTH] = {$random(seed)};
            if ({$random(seed)} % 8 == 0)
            begin
                beat[i*LANE_WIDTH +: ADC_BITS] = THRESHOLD_LEVEL - 1;
            end
            else
            begin
                beat[i*LANE_WIDTH +: ADC_BITS] = {$random(seed)} % THRESHOLD_LEVEL;
            end
        end
        if (make_high)
        begin
            lane = {$random(seed)} % LANES;
            beat[lane*LANE_WIDTH +: ADC_BITS] = ({$random(seed)} % 4 == 0) ? THRESHOLD_LEVEL :
                THRESHOLD_LEVEL + {$random(seed)} % ((1 << ADC_BITS) - THRESHOLD_LEVEL);
        end
        s_tdata = beat;
    endtask

    // random gaps plus occasional long stalls
    task automatic drive_ready();
        if (stall_left > 0)
        begin
            m_tready = 1'b0;
            stall_left--;
        end
        else if ({$random(seed)} % 40 == 0)
        begin
            m_tready   = 1'b0;
            stall_left = 5 + {$random(seed)} % 16;
        end
        else
        begin
            m_tready = ({$random(seed)} % 10) < 7;
        end
    endtask

    // sample mid-cycle where values match what the next rising edge sees
    always @(negedge AXIS_ACLK)
    begin : monitor
        out_word_t word;
        string     name;
        logic      hit;
        logic      rec_done;
        if (AXIS_ARESETN)
        begin
            check_value("s_tready", 1'b1, s_tready);
            check_value("busy", exp_busy, busy);
            rec_done = 1'b0;
            hit      = 1'b0;
            if (m_tvalid && m_tready)
            begin
                if (expected.size() == 0)
                begin
                    abort_run("an output word arrived while no record was pending");
                end
                else
                begin
                    word = expected.pop_front();
                    if (word_idx < 2)
                        name = "header word";
                    else if (word_idx < 2 + 2 * PRE_LEN)
                        name = "pre-trigger word";
                    else
                        name = "trigger and post word";
                    check_value(name, word.data, m_tdata);
                    check_value("m_tuser", word.user, m_tuser);
                    check_value("m_tlast", word.last, m_tlast);
                    word_idx++;
                    if (m_tlast)
                    begin
                        records_seen++;
                    end
                    if (word.last)
                    begin
                        rec_done  = 1'b1;
                        word_idx  = 0;
                        ref_state = FILL;
                        ref_fill  = 0;
                    end
                end
            end
            // a beat taken in the same cycle as the last word starts the new fill
            if (s_tvalid)
            begin
                model_accept(s_tdata, hit);
            end
            // busy rises two cycles after the trigger beat and falls one after tlast
            if (rec_done)
                exp_busy = 1'b0;
            else if (hit_prev)
                exp_busy = 1'b1;
            hit_prev = hit;
        end
    end

    initial
    begin
        seed             = 32'hb529_c5ca;
        s_tdata          = '0;
        s_tvalid         = 1'b0;
        m_tready         = 1'b0;
        high_left        = 0;
        stall_left       = 0;
        ref_state        = FILL;
        ref_fill         = 0;
        ref_post_left    = 0;
        ref_prev_high    = 1'b0;
        ref_beat_cnt     = '0;
        word_idx         = 0;
        records_expected = 0;
        records_seen     = 0;
        exp_busy         = 1'b0;
        hit_prev         = 1'b0;

        wait (AXIS_ARESETN === 1'b1);
        for (int c = 0; c < N_CYCLES; c++)
        begin
            @(posedge AXIS_ACLK);
            #1;
            drive_input(1'b1);
            drive_ready();
        end

        // quiet samples until the last record is out
        while (!((ref_state == FILL) && (expected.size() == 0)))
        begin
            @(posedge AXIS_ACLK);
            #1;
            drive_input(1'b0);
            m_tready = 1'b1;
        end
        repeat (8) @(posedge AXIS_ACLK);

        check_value("record count", records_expected, records_seen);
        check_value("busy at end", 0, busy);
        if (records_expected == 0)
        begin
            abort_run("no trigger fired during the whole run");
        end
        else
        begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

    initial
    begin
        #((N_CYCLES * 4 + MARGIN_CYCLES) * CLK_NS);
        abort_run("timeout: the run did not complete within the time limit");
    end

endmodule

// File: flist.f
src/acq_pkg.sv
src/trigger_detect.sv
src/pretrig_ring_buffer.sv
src/stream_width_down.sv
src/acq_top.sv
bench/acq_clock_gen.sv
bench/acq_checker.sv
bench/acq_tb.sv

// File: src/acq_pkg.sv
package acq_pkg;

    // stream widths
    localparam int S_WIDTH = 128;
    localparam int M_WIDTH = 64;

    // sample lanes in one input beat
    localparam int LANES = 8;
    localparam int LANE_WIDTH = S_WIDTH / LANES;
    localparam int ADC_BITS = 12;

    // trigger level as a share of full scale, 4096 * 10 / 100 = 409
    localparam int THRESHOLD_PERCENT = 10;
    localparam int THRESHOLD_LEVEL = (1 << ADC_BITS) * THRESHOLD_PERCENT / 100;

    // record window in input beats
    localparam int PRE_LEN = 4;
    localparam int POST_LEN = 11;
    // header + pre + trigger + post
    localparam int REC_BEATS = 1 + PRE_LEN + 1 + POST_LEN;

    localparam int STAMP_WIDTH = 16;

    // ring depth, next power of two above the record
    localparam int BUF_DEPTH = 1 << $clog2(REC_BEATS);
    localparam int PTR_WIDTH = $clog2(BUF_DEPTH);

    // detector output beat
    typedef struct packed {
        logic [S_WIDTH-1:0]     data;
        logic                   hit;
        logic [STAMP_WIDTH-1:0] stamp;
    } stage_beat_t;

    // record beat towards the width converter
    typedef struct packed {
        logic [S_WIDTH-1:0] data;
        logic               first;
        logic               last;
    } wide_beat_t;

    // ring buffer phases
    typedef enum logic [1:0] {
        FILL,
        POST,
        DRAIN
    } buf_state_e;

endpackage

// File: src/acq_top.sv
`timescale 1ns/1ps

module acq_top (
    input  logic                        AXIS_ACLK,
    input  logic                        AXIS_ARESETN,
    input  logic [acq_pkg::S_WIDTH-1:0] s_tdata,
    input  logic                        s_tvalid,
    output logic                        s_tready,
    output logic [acq_pkg::M_WIDTH-1:0] m_tdata,
    output logic                        m_tvalid,
    input  logic                        m_tready,
    output logic                        m_tuser,
    output logic                        m_tlast,
    output logic                        busy
);
    import acq_pkg::*;

    stage_beat_t stage;
    logic        stage_valid;
    logic        armed;
    wide_beat_t  wide;
    logic        wide_valid;
    logic        wide_ready;

    // ADC stream cannot be stalled
    assign s_tready = 1'b1;

    trigger_detect u_trigger_detect (
        .AXIS_ACLK    (AXIS_ACLK),
        .AXIS_ARESETN (AXIS_ARESETN),
        .s_tdata      (s_tdata),
        .s_tvalid     (s_tvalid),
        .armed        (armed),
        .stage        (stage),
        .stage_valid  (stage_valid)
    );

    pretrig_ring_buffer u_ring_buffer (
        .AXIS_ACLK    (AXIS_ACLK),
        .AXIS_ARESETN (AXIS_ARESETN),
        .stage        (stage),
        .stage_valid  (stage_valid),
        .armed        (armed),
        .busy         (busy),
        .wide         (wide),
        .wide_valid   (wide_valid),
        .wide_ready   (wide_ready)
    );

    stream_width_down u_width_down (
        .AXIS_ACLK    (AXIS_ACLK),
        .AXIS_ARESETN (AXIS_ARESETN),
        .wide         (wide),
        .wide_valid   (wide_valid),
        .wide_ready   (wide_ready),
        .m_tdata      (m_tdata),
        .m_tvalid     (m_tvalid),
        .m_tready     (m_tready),
        .m_tuser      (m_tuser),
        .m_tlast      (m_tlast)
    );

endmodule

// File: src/pretrig_ring_buffer.sv
`timescale 1ns/1ps

module pretrig_ring_buffer (
    input  logic                 AXIS_ACLK,
    input  logic                 AXIS_ARESETN,
    input  acq_pkg::stage_beat_t stage,
    input  logic                 stage_valid,
    output logic                 armed,
    output logic                 busy,
    output acq_pkg::wide_beat_t  wide,
    output logic                 wide_valid,
    input  logic                 wide_ready
);
    import acq_pkg::*;

    logic [S_WIDTH-1:0] mem [BUF_DEPTH];

    buf_state_e state;

    logic [PTR_WIDTH-1:0]             wr_ptr;
    logic [PTR_WIDTH-1:0]             rd_ptr;
    logic [$clog2(PRE_LEN+1)-1:0]     fill_cnt;
    logic [$clog2(POST_LEN)-1:0]      post_cnt;
    logic [$clog2(REC_BEATS+1)-1:0]   rd_cnt;
    logic [STAMP_WIDTH-1:0]           rec_stamp;

    logic wr_en;
    logic hit_in;
    logic post_done;
    logic rd_en;
    logic drain_done;

    // beats arriving during drain are dropped
    assign wr_en     = stage_valid && (state != DRAIN);
    assign hit_in    = stage_valid && stage.hit && (state == FILL);
    assign post_done = stage_valid && (state == POST) && (post_cnt == POST_LEN - 1);
    assign rd_en     = wide_valid && wide_ready;

    // last beat is held downstream, its high half transfer raises wide_ready
    assign drain_done = (state == DRAIN) && (rd_cnt == REC_BEATS) && wide_ready;

    // counts the beat being written this cycle as well
    assign armed = (state == FILL) &&
                   ((fill_cnt == PRE_LEN) || (stage_valid && (fill_cnt == PRE_LEN - 1)));

    assign busy = (state != FILL);

    // circular sample store
    always_ff @(posedge AXIS_ACLK)
    begin
        if (wr_en)
        begin
            mem[wr_ptr] <= stage.data;
        end
    end

    // trigger time stamp for the header beat
    always_ff @(posedge AXIS_ACLK)
    begin
        if (hit_in)
        begin
            rec_stamp <= stage.stamp;
        end
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            state    <= FILL;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fill_cnt <= '0;
            post_cnt <= '0;
            rd_cnt   <= '0;
        end
        else
        begin
            if (wr_en)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end

            case (state)
                FILL:
                begin
                    if (wr_en && (fill_cnt != PRE_LEN))
                    begin
                        fill_cnt <= fill_cnt + 1'b1;
                    end
                    if (hit_in)
                    begin
                        state    <= POST;
                        post_cnt <= '0;
                        // record starts PRE_LEN entries behind the trigger
                        rd_ptr   <= wr_ptr - PTR_WIDTH'(PRE_LEN);
                    end
                end

                POST:
                begin
                    if (stage_valid)
                    begin
                        post_cnt <= post_cnt + 1'b1;
                    end
                    if (post_done)
                    begin
                        state  <= DRAIN;
                        rd_cnt <= '0;
                    end
                end

                DRAIN:
                begin
                    if (rd_en)
                    begin
                        rd_cnt <= rd_cnt + 1'b1;
                        // header is not in memory
                        if (rd_cnt != 0)
                        begin
                            rd_ptr <= rd_ptr + 1'b1;
                        end
                    end
                    if (drain_done)
                    begin
                        state    <= FILL;
                        fill_cnt <= '0;
                    end
                end

                default:
                begin
                    state <= FILL;
                end
            endcase
        end
    end

    // read-out, no writes happen during drain so memory output is stable
    assign wide_valid = (state == DRAIN) && (rd_cnt != REC_BEATS);
    assign wide.data  = (rd_cnt == 0) ? {{(S_WIDTH-STAMP_WIDTH){1'b0}}, rec_stamp}
                                      : mem[rd_ptr];
    assign wide.first = (rd_cnt == 0);
    assign wide.last  = (rd_cnt == REC_BEATS - 1);

endmodule

// File: src/stream_width_down.sv
`timescale 1ns/1ps

module stream_width_down (
    input  logic                        AXIS_ACLK,
    input  logic                        AXIS_ARESETN,
    input  acq_pkg::wide_beat_t         wide,
    input  logic                        wide_valid,
    output logic                        wide_ready,
    output logic [acq_pkg::M_WIDTH-1:0] m_tdata,
    output logic                        m_tvalid,
    input  logic                        m_tready,
    output logic                        m_tuser,
    output logic                        m_tlast
);
    import acq_pkg::*;

    wide_beat_t hold;
    logic       full;
    // 0 selects the low half, 1 the high half
    logic       half;
    logic       xfer;
    logic       load;

    assign xfer = full && m_tready;

    // take a new beat when empty or as the high half leaves
    assign wide_ready = !full || (half && m_tready);
    assign load       = wide_valid && wide_ready;

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            full <= 1'b0;
            half <= 1'b0;
        end
        else if (load)
        begin
            full <= 1'b1;
            half <= 1'b0;
        end
        else if (xfer)
        begin
            if (half)
            begin
                full <= 1'b0;
            end
            half <= ~half;
        end
    end

    // holding register
    always_ff @(posedge AXIS_ACLK)
    begin
        if (load)
        begin
            hold <= wide;
        end
    end

    assign m_tvalid = full;
    assign m_tdata  = half ? hold.data[S_WIDTH-1 -: M_WIDTH] : hold.data[M_WIDTH-1:0];

    // record start on the low half, record end on the high half
    assign m_tuser = full && !half && hold.first;
    assign m_tlast = full && half && hold.last;

endmodule

// File: src/trigger_detect.sv
`timescale 1ns/1ps

module trigger_detect (
    input  logic                        AXIS_ACLK,
    input  logic                        AXIS_ARESETN,
    input  logic [acq_pkg::S_WIDTH-1:0] s_tdata,
    input  logic                        s_tvalid,
    input  logic                        armed,
    output acq_pkg::stage_beat_t        stage,
    output logic                        stage_valid
);
    import acq_pkg::*;

    logic [LANES-1:0]       lane_high;
    logic                   beat_high;
    logic                   prev_high;
    logic                   edge_hit;
    logic [STAMP_WIDTH-1:0] beat_cnt;

    // per-lane compare on the low ADC bits
    always_comb
    begin
        for (int i = 0; i < LANES; i++)
        begin
            lane_high[i] = (s_tdata[i*LANE_WIDTH +: ADC_BITS] >= THRESHOLD_LEVEL);
        end
    end

    assign beat_high = |lane_high;

    // rising edge only, and only while the buffer has enough history
    assign edge_hit = beat_high && !prev_high && armed;

    // free-running beat index and previous beat level
    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            beat_cnt  <= '0;
            prev_high <= 1'b0;
        end
        else if (s_tvalid)
        begin
            beat_cnt  <= beat_cnt + 1'b1;
            prev_high <= beat_high;
        end
    end

    // strobe follows the accepted beat by one cycle
    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            stage_valid <= 1'b0;
        end
        else
        begin
            stage_valid <= s_tvalid;
        end
    end

    // registered beat with its hit flag and stamp
    always_ff @(posedge AXIS_ACLK)
    begin
        if (s_tvalid)
        begin
            stage.data  <= s_tdata;
            stage.hit   <= edge_hit;
            // stamp is the count of beats before this one
            stage.stamp <= beat_cnt;
        end
    end

endmodule
